/* all.f */
hdl/usbdev_pkg.sv
hdl/ahb_slave_frontend.sv
hdl/usbdev_regs.sv
hdl/desc_ram.sv
hdl/ahb_usb_device.sv
testbench/ahb_usb_device_asserts.sv
testbench/tb_ahb_usb_device.sv

/* run.sh */
#!/usr/bin/env bash
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f all.f \
    --top-module tb_ahb_usb_device --Mdir obj_dir -o sim_tb

out=$(./obj_dir/sim_tb +verilator+error+limit+1000) || true
echo "$out"

grep -qx "Done: no errors" <<< "$out"
echo "simulation passed"

/* testbench/tb_ahb_usb_device.sv */
module tb_ahb_usb_device;
    timeunit 1ns;
    timeprecision 1ps;

    import usbdev_pkg::*;

    logic              hclk;
    logic              hresetn;
    logic              hsel;
    logic [ADDR_W-1:0] haddr;
    logic [1:0]        htrans;
    logic [2:0]        hsize;
    logic              hwrite;
    logic              hready_in;
    logic [31:0]       hwdata;
    logic              hready_o;
    logic              hresp_o;
    logic [31:0]       hrdata_o;
    status_t           status;
    logic [DESC_AW-1:0] desc_raddr;
    logic [7:0]        desc_rdata_o;
    desc_table_t       desc_table_o;
    logic              usb_nrst_o;
    int                timeouts;
    int                errors;
    logic [DESC_AW-1:0] daddr;

    ahb_usb_device #(
        .ADDR_W(ADDR_W),
        .REG_NUM(REG_NUM),
        .DESC_LEN(DESC_LEN)
    ) ahb_usb_device_inst (
        .hclk(hclk),
        .hresetn(hresetn),
        .hsel_i(hsel),
        .haddr_i(haddr),
        .htrans_i(htrans),
        .hsize_i(hsize),
        .hwrite_i(hwrite),
        .hready_i(hready_in),
        .hwdata_i(hwdata),
        .hready_o(hready_o),
        .hresp_o(hresp_o),
        .hrdata_o(hrdata_o),
        .status_i(status),
        .desc_raddr_i(desc_raddr),
        .desc_rdata_o(desc_rdata_o),
        .desc_table_o(desc_table_o),
        .usb_nrst_o(usb_nrst_o)
    );

    // 100 ns clock
    initial begin
        hclk = 1'b0;
        forever #50 hclk = ~hclk;
    end

    // single transfer with address phase then data phase until hready_o
    task automatic bus_xfer(input logic wr, input logic [ADDR_W-1:0] addr,
                            input logic [2:0] size, input logic [31:0] data);
        int t;
        hsel   = 1'b1;
        htrans = 2'b10;
        haddr  = addr;
        hsize  = size;
        hwrite = wr;
        // new status for every transfer
        status = status_t'($urandom);
        @(posedge hclk);
        #10;
        hsel   = 1'b0;
        htrans = 2'b00;
        hwrite = 1'b0;
        hwdata = data;
        t = 0;
        while (!hready_o && t < 20) begin
            @(posedge hclk);
            #10;
            t++;
        end
        if (t >= 20) begin
            timeouts++;
            $display("timeout at %0t: hready_o stayed low", $time);
        end
        @(posedge hclk);
        #10;
    endtask

    initial begin
        void'($urandom(60));
        timeouts   = 0;
        hresetn    = 1'b0;
        hsel       = 1'b0;
        haddr      = '0;
        htrans     = 2'b00;
        hsize      = 3'd2;
        hwrite     = 1'b0;
        hready_in  = 1'b1;
        hwdata     = '0;
        status     = '0;
        desc_raddr = '0;
        repeat (8) @(posedge hclk);
        #10;
        hresetn = 1'b1;
        @(posedge hclk);
        #10;

        // register writes of every size with the enable bit kept clear
        for (int i = 0; i < 40; i++) begin
            logic [3:0] idx;
            logic [1:0] lo;
            idx = 4'($urandom % 16);
            lo  = 2'($urandom);
            bus_xfer(1'b1, {1'b1, 5'd0, idx, lo}, 3'($urandom % 3),
                     $urandom & ~32'h0001_0000);
            bus_xfer(1'b0, {1'b1, 5'd0, idx, 2'b00}, 3'd2, '0);
        end

        // descriptor bytes with the core disabled
        for (int k = 0; k < 16; k++) begin
            daddr = DESC_AW'(k * 37 + 3);
            bus_xfer(1'b1, {2'b00, daddr}, 3'd0, $urandom);
            bus_xfer(1'b0, {2'b00, daddr}, 3'd0, '0);
        end

        // enable the core so bus writes get dropped
        bus_xfer(1'b1, {1'b1, 11'd0}, 3'd2, 32'h0001_0000);
        // reg 0 read back with live status overlay
        bus_xfer(1'b0, {1'b1, 11'd0}, 3'd2, '0);
        for (int k = 0; k < 16; k++) begin
            daddr = DESC_AW'(k * 37 + 3);
            bus_xfer(1'b1, {2'b00, daddr}, 3'd0, $urandom);
            bus_xfer(1'b0, {2'b00, daddr}, 3'd0, '0);
        end

        // link port reads
        for (int k = 0; k < 16; k++) begin
            desc_raddr = DESC_AW'(k * 37 + 3);
            @(posedge hclk);
            #10;
        end
        // let the last link byte reach its check
        repeat (3) @(posedge hclk);
        #10;

        errors = ahb_usb_device_inst.asserts_inst.fail_cnt + timeouts;
        $display("errors: %0d assertion failures, %0d timeouts",
                 ahb_usb_device_inst.asserts_inst.fail_cnt, timeouts);
        if (errors == 0) begin
            $display("Done: no errors");
        end else begin
            $display("Done: errors found");
        end
        $finish;
    end

endmodule

/* testbench/ahb_usb_device_asserts.sv */
module ahb_usb_device_asserts #(
    parameter int ADDR_W  = usbdev_pkg::ADDR_W,
    parameter int REG_NUM = usbdev_pkg::REG_NUM
) (
    input logic                           hclk,
    input logic                           hresetn,
    input logic                           hsel_i,
    input logic [ADDR_W-1:0]              haddr_i,
    input logic [1:0]                     htrans_i,
    input logic [2:0]                     hsize_i,
    input logic                           hwrite_i,
    input logic                           hready_i,
    input logic [31:0]                    hwdata_i,
    input logic                           hready_o,
    input logic                           hresp_o,
    input logic [31:0]                    hrdata_o,
    input usbdev_pkg::status_t            status_i,
    input logic [usbdev_pkg::DESC_AW-1:0] desc_raddr_i,
    input logic [7:0]                     desc_rdata_o,
    input usbdev_pkg::desc_table_t        desc_table_o,
    input logic                           usb_nrst_o
);
    timeunit 1ns;
    timeprecision 1ps;

    import usbdev_pkg::*;

    int          fail_cnt = 0;
    // shadow registers and descriptor bytes
    logic [31:0] sh [REG_NUM];
    logic [7:0]  mem_sh [DESC_LEN];
    logic        written [DESC_LEN];
    logic [ADDR_W-1:0] a_q;
    logic [3:0]  s_q;
    logic        wr_q;
    logic        rd_q;
    logic        drd2;
    logic        link_chk;
    logic [7:0]  link_exp;
    logic        take;
    logic        en_sh;
    logic        reg_q;
    logic [3:0]  lanes;
    logic [31:0] rd_exp;
    desc_table_t tbl_exp;

    // entry word split by hand, length low and address high
    function automatic desc_entry_t split_entry(input logic [31:0] w);
        desc_entry_t e;
        e.addr = w[31:16];
        e.len  = w[15:0];
        return e;
    endfunction

    assign take  = hsel_i & hready_i & htrans_i[1];
    assign en_sh = sh[0][CR_EN_BIT];
    assign reg_q = a_q[ADDR_W-1];

    // lanes by transfer size
    always_comb begin
        if (hsize_i == 3'd0) begin
            lanes = 4'b0001 << haddr_i[1:0];
        end else if (hsize_i == 3'd1) begin
            lanes = haddr_i[1] ? 4'b1100 : 4'b0011;
        end else begin
            lanes = 4'b1111;
        end
    end

    // expected read word with live status in reg 0
    always_comb begin
        rd_exp = sh[a_q[5:2]];
        if (a_q[5:2] == 4'd0) begin
            rd_exp[2:0] = status_i;
        end
    end

    // descriptor table decode of the shadow
    always_comb begin
        tbl_exp.dev          = split_entry(sh[1]);
        tbl_exp.qual         = split_entry(sh[2]);
        tbl_exp.fscfg        = split_entry(sh[3]);
        tbl_exp.hscfg        = split_entry(sh[4]);
        tbl_exp.hidrpt       = split_entry(sh[6]);
        tbl_exp.bos          = split_entry(sh[7]);
        tbl_exp.strvendor    = split_entry(sh[8]);
        tbl_exp.strproduct   = split_entry(sh[9]);
        tbl_exp.strserial    = split_entry(sh[10]);
        tbl_exp.strlang_addr = sh[5][15:0];
        tbl_exp.oscfg_addr   = sh[5][31:16];
        tbl_exp.has_strings  = sh[11][0];
    end

    // ------------------------------------------------------------------------
    // shadow model
    // ------------------------------------------------------------------------

    always_ff @(posedge hclk or negedge hresetn) begin
        if (!hresetn) begin
            for (int r = 0; r < REG_NUM; r++) begin
                sh[r] <= '0;
            end
            for (int m = 0; m < DESC_LEN; m++) begin
                written[m] <= 1'b0;
            end
            a_q      <= '0;
            s_q      <= '0;
            wr_q     <= 1'b0;
            rd_q     <= 1'b0;
            drd2     <= 1'b0;
            link_chk <= 1'b0;
        end else begin
            wr_q <= take & hwrite_i;
            rd_q <= take & ~hwrite_i;
            if (take) begin
                a_q <= haddr_i;
                s_q <= lanes;
            end
            // second cycle of a descriptor read
            drd2 <= rd_q & ~reg_q;
            if (wr_q && reg_q) begin
                for (int b = 0; b < 4; b++) begin
                    if (s_q[b]) begin
                        sh[a_q[5:2]][8*b +: 8] <= hwdata_i[8*b +: 8];
                    end
                end
            end
            if (wr_q && !reg_q && !en_sh) begin
                written[a_q[DESC_AW-1:0]] <= 1'b1;
            end
            link_chk <= en_sh & written[desc_raddr_i];
        end
    end

    always_ff @(posedge hclk) begin
        if (hresetn && wr_q && !reg_q && !en_sh) begin
            mem_sh[a_q[DESC_AW-1:0]] <= hwdata_i[7:0];
        end
        link_exp <= mem_sh[desc_raddr_i];
    end

    // ------------------------------------------------------------------------
    // checks
    // ------------------------------------------------------------------------

    a_hresp: assert property (@(posedge hclk) hresp_o == 1'b0)
        else begin
            fail_cnt++;
            $error("mismatch %0t: hresp_o not OKAY", $time);
        end

    // one wait state on descriptor reads only
    a_wait: assert property (@(posedge hclk) disable iff (!hresetn)
        (rd_q && !reg_q) == !hready_o)
        else begin
            fail_cnt++;
            $error("mismatch %0t: hready_o wait state", $time);
        end

    a_regrd: assert property (@(posedge hclk) disable iff (!hresetn)
        rd_q && reg_q |-> hrdata_o == rd_exp)
        else begin
            fail_cnt++;
            $error("mismatch %0t: register read data", $time);
        end

    a_descrd: assert property (@(posedge hclk) disable iff (!hresetn)
        drd2 && written[a_q[DESC_AW-1:0]] |-> hrdata_o == {4{mem_sh[a_q[DESC_AW-1:0]]}})
        else begin
            fail_cnt++;
            $error("mismatch %0t: descriptor read data", $time);
        end

    a_table: assert property (@(posedge hclk) desc_table_o == tbl_exp)
        else begin
            fail_cnt++;
            $error("mismatch %0t: descriptor table", $time);
        end

    a_nrst: assert property (@(posedge hclk) usb_nrst_o == (en_sh & hresetn))
        else begin
            fail_cnt++;
            $error("mismatch %0t: usb_nrst_o", $time);
        end

    a_link: assert property (@(posedge hclk) disable iff (!hresetn)
        link_chk |-> desc_rdata_o == link_exp)
        else begin
            fail_cnt++;
            $error("mismatch %0t: link port byte", $time);
        end

endmodule

bind ahb_usb_device ahb_usb_device_asserts #(
    .ADDR_W(ADDR_W),
    .REG_NUM(REG_NUM)
) asserts_inst (.*);

/* hdl/ahb_usb_device.sv */
module ahb_usb_device #(
    parameter int ADDR_W   = usbdev_pkg::ADDR_W,
    parameter int REG_NUM  = usbdev_pkg::REG_NUM,
    parameter int DESC_LEN = usbdev_pkg::DESC_LEN
) (
    input  logic                           hclk,
    input  logic                           hresetn,
    // ahb-lite slave
    input  logic                           hsel_i,
    input  logic [ADDR_W-1:0]              haddr_i,
    input  logic [1:0]                     htrans_i,
    input  logic [2:0]                     hsize_i,
    input  logic                           hwrite_i,
    input  logic                           hready_i,
    input  logic [31:0]                    hwdata_i,
    output logic                           hready_o,
    output logic                           hresp_o,
    output logic [31:0]                    hrdata_o,
    // link controller side
    input  usbdev_pkg::status_t            status_i,
    input  logic [usbdev_pkg::DESC_AW-1:0] desc_raddr_i,
    output logic [7:0]                     desc_rdata_o,
    output usbdev_pkg::desc_table_t        desc_table_o,
    output logic                           usb_nrst_o
);

    import usbdev_pkg::*;

    ahb_req_t    req;
    logic [31:0] reg_rdata;
    logic [7:0]  ram_rdata;
    // core enable, steers ram port ownership
    logic        cr_en;

    ahb_slave_frontend #(
        .ADDR_W(ADDR_W)
    ) ahb_slave_frontend_inst (
        .hclk(hclk),
        .hresetn(hresetn),
        .hsel_i(hsel_i),
        .haddr_i(haddr_i),
        .htrans_i(htrans_i),
        .hsize_i(hsize_i),
        .hwrite_i(hwrite_i),
        .hready_i(hready_i),
        .reg_rdata_i(reg_rdata),
        .ram_rdata_i(ram_rdata),
        .req_o(req),
        .hready_o(hready_o),
        .hresp_o(hresp_o),
        .hrdata_o(hrdata_o)
    );

    usbdev_regs #(
        .ADDR_W(ADDR_W),
        .REG_NUM(REG_NUM)
    ) usbdev_regs_inst (
        .hclk(hclk),
        .hresetn(hresetn),
        .req_i(req),
        .wdata_i(hwdata_i),
        .status_i(status_i),
        .rdata_o(reg_rdata),
        .cr_en_o(cr_en),
        .desc_table_o(desc_table_o),
        .usb_nrst_o(usb_nrst_o)
    );

    desc_ram #(
        .ADDR_W(ADDR_W),
        .DESC_LEN(DESC_LEN)
    ) desc_ram_inst (
        .hclk(hclk),
        .req_i(req),
        .wdata_i(hwdata_i),
        .cr_en_i(cr_en),
        .link_raddr_i(desc_raddr_i),
        .bus_rdata_o(ram_rdata),
        .link_rdata_o(desc_rdata_o)
    );

endmodule

/* hdl/desc_ram.sv */
module desc_ram #(
    parameter int ADDR_W   = usbdev_pkg::ADDR_W,
    parameter int DESC_LEN = usbdev_pkg::DESC_LEN
) (
    input  logic                         hclk,
    // bus port
    input  usbdev_pkg::ahb_req_t         req_i,
    input  logic [31:0]                  wdata_i,
    input  logic                         cr_en_i,
    // link port
    input  logic [usbdev_pkg::DESC_AW-1:0] link_raddr_i,
    output logic [7:0]                   bus_rdata_o,
    output logic [7:0]                   link_rdata_o
);

    import usbdev_pkg::*;

    logic [7:0]         mem [DESC_LEN];
    logic [DESC_AW-1:0] bus_addr;
    logic               bus_wr;

    // byte address from the held request
    assign bus_addr = req_i.addr[DESC_AW-1:0];

    // descriptor region write, only while the core is off
    // writes with the core on are dropped
    assign bus_wr = req_i.wr_en & ~req_i.addr[ADDR_W-1] & ~cr_en_i;

    // ------------------------------------------------------------------------
    // bus port
    // ------------------------------------------------------------------------

    // byte lane 0 only
    always_ff @(posedge hclk) begin
        if (bus_wr) begin
            mem[bus_addr] <= wdata_i[7:0];
        end
    end

    // sync read every cycle
    // front end holds hready low until this is valid
    always_ff @(posedge hclk) begin
        bus_rdata_o <= mem[bus_addr];
    end

    // ------------------------------------------------------------------------
    // link port
    // ------------------------------------------------------------------------

    // enabled only while the core runs, holds otherwise
    always_ff @(posedge hclk) begin
        if (cr_en_i) begin
            link_rdata_o <= mem[link_raddr_i];
        end
    end

endmodule

/* hdl/usbdev_regs.sv */
module usbdev_regs #(
    parameter int ADDR_W  = usbdev_pkg::ADDR_W,
    parameter int REG_NUM = usbdev_pkg::REG_NUM
) (
    input  logic                    hclk,
    input  logic                    hresetn,
    input  usbdev_pkg::ahb_req_t    req_i,
    input  logic [31:0]             wdata_i,
    input  usbdev_pkg::status_t     status_i,
    output logic [31:0]             rdata_o,
    output logic                    cr_en_o,
    output usbdev_pkg::desc_table_t desc_table_o,
    output logic                    usb_nrst_o
);

    import usbdev_pkg::*;

    // word index from address bits 5:2 for 16 regs
    localparam int IDX_W = $clog2(REG_NUM);

    logic [31:0]      regs_q [REG_NUM];
    logic [IDX_W-1:0] idx;
    logic             reg_wr;

    assign idx    = req_i.addr[IDX_W+1:2];
    // register region is the upper half of the map
    assign reg_wr = req_i.wr_en & req_i.addr[ADDR_W-1];

    // ------------------------------------------------------------------------
    // byte-strobe writes
    // ------------------------------------------------------------------------

    always_ff @(posedge hclk or negedge hresetn) begin
        if (!hresetn) begin
            for (int r = 0; r < REG_NUM; r++) begin
                regs_q[r] <= '0;
            end
        end else if (reg_wr) begin
            // only lanes with strobe set
            for (int b = 0; b < 4; b++) begin
                if (req_i.strobe[b]) begin
                    regs_q[idx][8*b +: 8] <= wdata_i[8*b +: 8];
                end
            end
        end
    end

    // ------------------------------------------------------------------------
    // read back
    // ------------------------------------------------------------------------

    // register 0 shows live status in its low bits
    always_comb begin
        rdata_o = regs_q[idx];
        if (idx == IDX_W'(REG_IDX_STATUS)) begin
            rdata_o[STATUS_W-1:0] = status_i;
        end
    end

    // core enable and link reset
    assign cr_en_o    = regs_q[REG_IDX_STATUS][CR_EN_BIT];
    assign usb_nrst_o = cr_en_o & hresetn;

    // ------------------------------------------------------------------------
    // descriptor table decode
    // ------------------------------------------------------------------------

    // entry regs map 1:1 onto desc_entry_t, addr high and len low
    assign desc_table_o.dev        = desc_entry_t'(regs_q[REG_IDX_DEV]);
    assign desc_table_o.qual       = desc_entry_t'(regs_q[REG_IDX_QUAL]);
    assign desc_table_o.fscfg      = desc_entry_t'(regs_q[REG_IDX_FSCFG]);
    assign desc_table_o.hscfg      = desc_entry_t'(regs_q[REG_IDX_HSCFG]);
    assign desc_table_o.hidrpt     = desc_entry_t'(regs_q[REG_IDX_HIDRPT]);
    assign desc_table_o.bos        = desc_entry_t'(regs_q[REG_IDX_BOS]);
    assign desc_table_o.strvendor  = desc_entry_t'(regs_q[REG_IDX_STRVENDOR]);
    assign desc_table_o.strproduct = desc_entry_t'(regs_q[REG_IDX_STRPRODUCT]);
    assign desc_table_o.strserial  = desc_entry_t'(regs_q[REG_IDX_STRSERIAL]);

    // register 5 holds two addresses, no length
    assign desc_table_o.strlang_addr = regs_q[REG_IDX_STRLANG][15:0];
    assign desc_table_o.oscfg_addr   = regs_q[REG_IDX_STRLANG][31:16];

    // string descriptors present
    assign desc_table_o.has_strings = regs_q[REG_IDX_HASSTR][0];

endmodule

/* hdl/ahb_slave_frontend.sv */
module ahb_slave_frontend #(
    parameter int ADDR_W = usbdev_pkg::ADDR_W
) (
    input  logic                 hclk,
    input  logic                 hresetn,
    // ahb-lite slave side
    input  logic                 hsel_i,
    input  logic [ADDR_W-1:0]    haddr_i,
    input  logic [1:0]           htrans_i,
    input  logic [2:0]           hsize_i,
    input  logic                 hwrite_i,
    input  logic                 hready_i,
    // read sources
    input  logic [31:0]          reg_rdata_i,
    input  logic [7:0]           ram_rdata_i,
    // registered request to the register bank and ram
    output usbdev_pkg::ahb_req_t req_o,
    output logic                 hready_o,
    output logic                 hresp_o,
    output logic [31:0]          hrdata_o
);

    import usbdev_pkg::*;

    // accepted transfer, SEQ or NONSEQ only
    logic       trans_req;
    logic       rd_req;
    logic       wr_req;
    // enable updates, new request or end of the current one
    logic       upd_rd;
    logic       upd_wr;
    logic [3:0] strobe_nxt;
    ahb_req_t   req_q;
    logic       hready_q;

    assign trans_req = hsel_i & hready_i & htrans_i[1];
    assign rd_req    = trans_req & ~hwrite_i;
    assign wr_req    = trans_req & hwrite_i;

    assign upd_rd = rd_req | (req_q.rd_en & hready_i);
    assign upd_wr = wr_req | (req_q.wr_en & hready_i);

    // byte lanes from hsize and low address bits
    always_comb begin
        case (hsize_i)
            3'b000: strobe_nxt = 4'b0001 << haddr_i[1:0];
            3'b001: strobe_nxt = haddr_i[1] ? 4'b1100 : 4'b0011;
            // word and anything wider
            default: strobe_nxt = 4'b1111;
        endcase
    end

    // ------------------------------------------------------------------------
    // address phase capture
    // ------------------------------------------------------------------------

    always_ff @(posedge hclk or negedge hresetn) begin
        if (!hresetn) begin
            req_q <= '0;
        end else begin
            if (trans_req) begin
                req_q.addr   <= haddr_i;
                req_q.strobe <= strobe_nxt;
            end
            // cleared once the data phase completes with no new request
            if (upd_rd) begin
                req_q.rd_en <= rd_req;
            end
            if (upd_wr) begin
                req_q.wr_en <= wr_req;
            end
        end
    end

    // ------------------------------------------------------------------------
    // wait state
    // ------------------------------------------------------------------------

    // sync ram output needs one extra cycle
    // register reads and all writes complete without wait
    always_ff @(posedge hclk or negedge hresetn) begin
        if (!hresetn) begin
            hready_q <= 1'b1;
        end else begin
            hready_q <= ~(rd_req & ~haddr_i[ADDR_W-1]);
        end
    end

    assign req_o    = req_q;
    assign hready_o = hready_q;
    // slave never errors
    assign hresp_o  = 1'b0;

    // region bit of the held address picks the source
    // descriptor region is byte wide, replicated on all lanes
    always_comb begin
        if (req_q.addr[ADDR_W-1]) begin
            hrdata_o = reg_rdata_i;
        end else begin
            hrdata_o = {4{ram_rdata_i}};
        end
    end

endmodule

/* hdl/usbdev_pkg.sv */
package usbdev_pkg;

    // ------------------------------------------------------------------------
    // address map and sizes
    // ------------------------------------------------------------------------

    // ahb address width, top bit picks the register region
    parameter int ADDR_W   = 12;
    // control and descriptor-table registers
    parameter int REG_NUM  = 16;
    // descriptor ram bytes
    parameter int DESC_LEN = 1024;
    parameter int DESC_AW  = 10;

    // ------------------------------------------------------------------------
    // register indices, address bits 5:2
    // ------------------------------------------------------------------------

    // control and status
    parameter int REG_IDX_STATUS     = 0;
    // descriptor entries, len in 15:0 and addr in 31:16
    parameter int REG_IDX_DEV        = 1;
    parameter int REG_IDX_QUAL       = 2;
    parameter int REG_IDX_FSCFG      = 3;
    parameter int REG_IDX_HSCFG      = 4;
    // lang string addr low half, other-speed cfg addr high half
    parameter int REG_IDX_STRLANG    = 5;
    parameter int REG_IDX_HIDRPT     = 6;
    parameter int REG_IDX_BOS        = 7;
    parameter int REG_IDX_STRVENDOR  = 8;
    parameter int REG_IDX_STRPRODUCT = 9;
    parameter int REG_IDX_STRSERIAL  = 10;
    // bit 0 only
    parameter int REG_IDX_HASSTR     = 11;

    // core enable in register 0
    parameter int CR_EN_BIT = 16;
    // live status overlaid on register 0 bits 2:0
    parameter int STATUS_W  = 3;

    // ------------------------------------------------------------------------
    // types
    // ------------------------------------------------------------------------

    // link status, hispeed lands on bit 2
    typedef struct packed {
        logic hispeed;
        logic suspend;
        logic online;
    } status_t;

    // data-phase request held by the ahb front end
    typedef struct packed {
        logic [ADDR_W-1:0] addr;
        logic              rd_en;
        logic              wr_en;
        logic [3:0]        strobe;
    } ahb_req_t;

    // same layout as a descriptor register word
    typedef struct packed {
        logic [15:0] addr;
        logic [15:0] len;
    } desc_entry_t;

    // everything the link controller needs to serve GET_DESCRIPTOR
    typedef struct packed {
        desc_entry_t dev;
        desc_entry_t qual;
        desc_entry_t fscfg;
        desc_entry_t hscfg;
        desc_entry_t hidrpt;
        desc_entry_t bos;
        desc_entry_t strvendor;
        desc_entry_t strproduct;
        desc_entry_t strserial;
        logic [15:0] strlang_addr;
        logic [15:0] oscfg_addr;
        logic        has_strings;
    } desc_table_t;

endpackage
